/* Makefile */
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed

SRCS := $(wildcard common/*.sv mem_stage/*.sv bench/*.sv bench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_mem_tasks.svh */
/*
 * value check, word issue with stall checks, and the directed tests
 */

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // i-type layout, enough for decode which looks at opcode, funct3 and rd
    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_i = {12'h010, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2);
        enc_s = {7'd0, rs2, 5'd1, f3, 5'd0, OPC_STORE};
    endfunction

    // one word through the stage, waits for out_valid and records the outputs
    task automatic issue(input logic [INST_W-1:0] inst, input logic [XLEN-1:0] alu,
                         input logic [XLEN-1:0] src2);
        logic [PC_W-1:0]   pc;
        logic [XLEN-1:0]   addr0;
        logic [XLEN-1:0]   data0;
        logic [STRB_W-1:0] strb0;
        int                waited;
        waited = 0;
        pc     = pc_ctr;
        pc_ctr = pc_ctr + 4;
        @(negedge clk);
        in_valid      = 1'b1;
        in_pc         = pc;
        in_inst       = inst;
        in_alu_result = alu;
        in_src2       = src2;
        #1;
        check("in_ready before capture", in_ready, 1);
        @(negedge clk);
        in_valid = 1'b0;   // bubble behind it
        #1;
        addr0 = dmem_addr;
        data0 = dmem_wdata;
        strb0 = dmem_wstrb;
        check("dmem_addr", addr0, alu);
        while (!out_valid && waited < WORD_WAIT) begin
            check("in_ready while stalled", in_ready, 0);
            check("rf_wen while stalled", rf_wen, 0);
            check("dmem_req while stalled", dmem_req, 1);
            check("dmem_addr stable", dmem_addr, addr0);
            check("dmem_wdata stable", dmem_wdata, data0);
            check("dmem_wstrb stable", dmem_wstrb, strb0);
            @(negedge clk);
            #1;
            waited++;
        end
        if (!out_valid) begin
            $display("no result from the stage within %0d cycles of capture", WORD_WAIT);
            errors++;
        end
        check("out_inst", out_inst, inst);
        check("out_pc", out_pc, pc);
        res_wen   = rf_wen;
        res_waddr = rf_waddr;
        res_wdata = rf_wdata;
        res_we    = dmem_we;
        res_mdata = dmem_wdata;
        res_wstrb = dmem_wstrb;
    endtask

    task automatic test_reset_state();
        check("in_ready after reset", in_ready, 1);
        check("out_valid after reset", out_valid, 0);
        check("rf_wen after reset", rf_wen, 0);
        check("dmem_req after reset", dmem_req, 0);
    endtask

    task automatic test_alu_writeback();
        logic [6:0]      opcs [7] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL,
                                      OPC_OP_32, OPC_AUIPC, OPC_JALR};
        logic [XLEN-1:0] alu;
        for (int k = 0; k < 7; k++) begin
            alu = {$random(seed), $random(seed)};
            issue(enc_i(opcs[k], 3'b000, 5'(k + 3)), alu, 64'h5555);
            check("alu rf_wen", res_wen, 1);
            check("alu rf_waddr", res_waddr, k + 3);
            check("alu rf_wdata", res_wdata, alu);
        end
    endtask

    task automatic test_csr_writeback();
        logic [XLEN-1:0] old_csr;
        for (int k = 0; k < 2; k++) begin
            old_csr = {$random(seed), $random(seed)};
            issue(enc_i(OPC_SYSTEM, (k == 0) ? F3_CSRRW : F3_CSRRS, 5'(k + 7)),
                  64'hdead_beef, old_csr);
            check("csr rf_wen", res_wen, 1);
            check("csr rf_waddr", res_waddr, k + 7);
            check("csr rf_wdata", res_wdata, old_csr);
        end
    endtask

    // sb/sh/sw/sd at every aligned offset, each into its own word
    task automatic test_store_align();
        int              idx;
        int              nbytes;
        logic [XLEN-1:0] src;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] mask;
        idx = 8;
        for (int sz = 0; sz < 4; sz++) begin
            nbytes = 1 << sz;
            mask   = (64'd1 << (8 * nbytes)) - 1;   // wraps to all ones for sd
            for (int ofs = 0; ofs < 8; ofs += nbytes) begin
                src = {$random(seed), $random(seed)};
                old = mem[idx];
                issue(enc_s(3'(sz), 5'd9), 64'(idx * 8 + ofs), src);
                check("store dmem_we", res_we, 1);
                check("store strobes", res_wstrb, ((1 << nbytes) - 1) << ofs);
                check("store data", res_mdata, (src & mask) << (8 * ofs));
                check("store rf_wen", res_wen, 0);
                @(negedge clk);   // model wrote on the edge after ready
                check("store readback", mem[idx],
                      (old & ~(mask << (8 * ofs))) | ((src & mask) << (8 * ofs)));
                idx++;
            end
        end
    endtask

    task automatic test_load_extend();
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] exp;
        int              nbytes;
        logic            uns;
        word          = 64'h81f2_63d4_75b6_f788;   // mixed sign bits per lane
        mem[LOAD_IDX] = word;
        for (int f = 0; f < 7; f++) begin   // lb lh lw ld lbu lhu lwu
            nbytes = 1 << (f & 3);
            uns    = (f >= 4);
            mask   = (64'd1 << (8 * nbytes)) - 1;
            for (int ofs = 0; ofs < 8; ofs += nbytes) begin
                exp = (word >> (8 * ofs)) & mask;
                if (!uns && exp[8*nbytes-1]) exp = exp | ~mask;
                issue(enc_i(OPC_LOAD, 3'(f), 5'(10 + ofs)), 64'(LOAD_IDX * 8 + ofs), 64'h0);
                check("load dmem_we", res_we, 0);
                check("load rf_wen", res_wen, 1);
                check("load rf_waddr", res_waddr, 10 + ofs);
                check("load rf_wdata", res_wdata, exp);
            end
        end
    endtask

    task automatic store_fwd(input string what, input logic [REG_W-1:0] rs2,
                             input logic fwd_wen, input logic [REG_W-1:0] fwd_rd,
                             input int idx, input logic [XLEN-1:0] src,
                             input logic [XLEN-1:0] fwd, input logic [XLEN-1:0] exp);
        @(negedge clk);
        wb_wen   = fwd_wen;
        wb_rd    = fwd_rd;
        wb_wdata = fwd;
        issue(enc_s(F3_D, rs2), 64'(idx * 8), src);
        check(what, res_mdata, exp);
        @(negedge clk);
        wb_wen = 1'b0;
        check({what, " readback"}, mem[idx], exp);
    endtask

    task automatic test_forwarding();
        logic [XLEN-1:0] src;
        logic [XLEN-1:0] fwd;
        src = 64'h1111_2222_3333_4444;
        fwd = 64'h9999_aaaa_bbbb_cccc;
        store_fwd("fwd from wb", 5'd5, 1'b1, 5'd5, 30, src, fwd, fwd);
        store_fwd("no fwd for x0", 5'd0, 1'b1, 5'd0, 31, src, fwd, src);
        store_fwd("no fwd without wb_wen", 5'd5, 1'b0, 5'd5, 32, src, fwd, src);
    endtask

    // wb stalls, a second word waits in ex until out_ready returns
    task automatic test_out_ready_hold();
        logic [INST_W-1:0] i1;
        logic [INST_W-1:0] i2;
        i1 = enc_i(OPC_OP, 3'b000, 5'd20);
        i2 = enc_i(OPC_OP_IMM, 3'b000, 5'd21);
        @(negedge clk);
        in_valid      = 1'b1;
        in_pc         = pc_ctr;
        in_inst       = i1;
        in_alu_result = 64'h0123_4567_89ab_cdef;
        @(negedge clk);
        out_ready     = 1'b0;
        in_inst       = i2;
        in_alu_result = 64'hfeed_face_0bad_f00d;
        for (int c = 0; c < 3; c++) begin
            #1;
            check("held out_valid", out_valid, 1);
            check("held out_inst", out_inst, i1);
            check("held rf_wdata", rf_wdata, 64'h0123_4567_89ab_cdef);
            check("in_ready with out_ready low", in_ready, 0);
            @(negedge clk);
        end
        out_ready = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        #1;
        check("next out_inst", out_inst, i2);
        check("next rf_waddr", rf_waddr, 21);
        check("next rf_wdata", rf_wdata, 64'hfeed_face_0bad_f00d);
    endtask

/* bench/tb_mem_stage.sv */
/*
 * testbench for the rv64 memory stage
 * clock, reset, dut, data memory with random latency, timeout and summary
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage import mem_stage_pkg::*; import rv_isa_pkg::*; ();

    localparam int N_STEPS     = 60;                  // words issued by all tests, rounded up
    localparam int CYCLE_LIMIT = 8 * N_STEPS + 40;    // 8 cycles per word plus reset and hold
    localparam int WORD_WAIT   = 8;                   // memory answers within 4
    localparam int MEM_WORDS   = 64;
    localparam int LOAD_IDX    = 4;                   // word used by the load tests

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic [PC_W-1:0]     in_pc;
    logic [INST_W-1:0]   in_inst;
    logic [XLEN-1:0]     in_alu_result;
    logic [XLEN-1:0]     in_src2;
    logic                out_valid;
    logic                out_ready;
    logic [PC_W-1:0]     out_pc;
    logic [INST_W-1:0]   out_inst;
    logic                rf_wen;
    logic [REG_W-1:0]    rf_waddr;
    logic [XLEN-1:0]     rf_wdata;
    logic                wb_wen;
    logic [REG_W-1:0]    wb_rd;
    logic [XLEN-1:0]     wb_wdata;
    logic                dmem_req;
    logic                dmem_we;
    logic [XLEN-1:0]     dmem_addr;
    logic [XLEN-1:0]     dmem_wdata;
    logic [STRB_W-1:0]   dmem_wstrb;
    logic [XLEN-1:0]     dmem_rdata;
    logic                dmem_ready;

    logic [XLEN-1:0]     mem [MEM_WORDS];   // data memory model
    logic                busy;              // request seen, answer pending
    int                  wait_left;
    integer              seed;
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;
    logic [PC_W-1:0]     pc_ctr;

    // result of the last issued word, taken in its output cycle
    logic                res_wen;
    logic [REG_W-1:0]    res_waddr;
    logic [XLEN-1:0]     res_wdata;
    logic                res_we;
    logic [XLEN-1:0]     res_mdata;
    logic [STRB_W-1:0]   res_wstrb;

    mem_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every word gets a distinct value, index in several fields
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        fill_word = {16'(idx), 16'hc0de, ~16'(idx), 16'(idx * 7)};
    endfunction

    function automatic int word_idx(input logic [XLEN-1:0] a);
        word_idx = int'(a[8:3]);   // low 3 bits are the lane offset
    endfunction

    // memory answers on a falling edge, 1 to 4 cycles after the request shows up
    always @(negedge clk) begin
        if (rst) begin
            dmem_ready = 1'b0;
            busy       = 1'b0;
        end else if (dmem_ready) begin
            dmem_ready = 1'b0;                   // one cycle pulse
            dmem_rdata = 64'hbad0_bad0_bad0_bad0;  // junk outside the ready cycle
            busy       = 1'b0;
        end else if (busy && !dmem_req) begin
            $display("memory request dropped before ready at %0t", $time);
            errors++;
            busy = 1'b0;
        end else if (busy) begin
            if (wait_left <= 1) begin
                dmem_ready = 1'b1;
                dmem_rdata = mem[word_idx(dmem_addr)];
            end
            wait_left = wait_left - 1;
        end else if (dmem_req) begin
            busy      = 1'b1;
            wait_left = 1 + ($random(seed) & 3);
        end
    end

    // stores land on the edge that ends the access
    always @(posedge clk) begin
        if (!rst && dmem_req && dmem_ready && dmem_we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (dmem_wstrb[b]) mem[word_idx(dmem_addr)][8*b +: 8] = dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, tests still running after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

`include "tb_mem_tasks.svh"

    initial begin
        seed          = 32'he103;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_alu_result = '0;
        in_src2       = '0;
        out_ready     = 1'b1;
        wb_wen        = 1'b0;
        wb_rd         = '0;
        wb_wdata      = '0;
        dmem_rdata    = '0;
        dmem_ready    = 1'b0;
        busy          = 1'b0;
        wait_left     = 0;
        pc_ctr        = 64'h8000_0000;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        test_reset_state();
        test_alu_writeback();
        test_csr_writeback();
        test_store_align();
        test_load_extend();
        test_forwarding();
        test_out_ready_hold();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/mem_stage_pkg.sv */
/*
 * memory stage sizing
 * datapath widths, strobe geometry and writeback source codes
 */
`default_nettype none

package mem_stage_pkg;

    // datapath
    localparam int XLEN   = 64;
    localparam int PC_W   = 64;
    localparam int INST_W = 32;

    // byte lanes of one data word
    localparam int STRB_W = XLEN / 8;
    localparam int OFS_W  = $clog2(STRB_W);   // 3 for 64-bit words

    // where the register file value comes from
    localparam int WB_SEL_W = 2;

    localparam logic [WB_SEL_W-1:0] WB_SEL_ALU  = 2'd0;   // alu result, also jal/jalr link
    localparam logic [WB_SEL_W-1:0] WB_SEL_LOAD = 2'd1;   // extended memory data
    localparam logic [WB_SEL_W-1:0] WB_SEL_SRC2 = 2'd2;   // old csr value rides on src2

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
/*
 * RV64I encoding constants used by the memory stage
 * opcodes, funct3 size and CSR codes, and the two instruction views
 */
`default_nettype none

package rv_isa_pkg;

    localparam int REG_W = 5;   // x0..x31

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // load/store width in funct3, bit 2 set for the unsigned loads
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    // csr ops that write rd
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;

    // same 32 bits, I-type for loads, S-type for stores
    typedef union packed {
        struct packed {
            logic [11:0]      imm;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } i;
        struct packed {
            logic [6:0]       imm_hi;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [4:0]       imm_lo;   // sits where rd is in the i view
            logic [6:0]       opcode;
        } s;
    } rv_inst_u;

endpackage

`default_nettype wire

/* flist.f */
+incdir+bench
common/rv_isa_pkg.sv
common/mem_stage_pkg.sv
mem_stage/mem_decode.sv
mem_stage/store_align.sv
mem_stage/load_result.sv
mem_stage/mem_stage_reg.sv
mem_stage/mem_stage.sv
bench/tb_mem_stage.sv

/* mem_stage/load_result.sv */
/*
 * load data extraction and register writeback select
 * byte/half/word/double pick with sign or zero extension
 */
`timescale 1ns/1ps
`default_nettype none

module load_result import mem_stage_pkg::*; import rv_isa_pkg::*; (
    input  logic [1:0]          size,
    input  logic                is_unsigned,
    input  logic [XLEN-1:0]     addr,
    input  logic [XLEN-1:0]     dmem_rdata,
    input  logic [XLEN-1:0]     alu_result,
    input  logic [XLEN-1:0]     src2,
    input  logic [WB_SEL_W-1:0] wb_sel,
    input  logic                valid,
    input  logic                blocked,
    input  logic                wen,
    input  logic [REG_W-1:0]    rd,
    output logic                rf_wen,
    output logic [REG_W-1:0]    rf_waddr,
    output logic [XLEN-1:0]     rf_wdata
);

    logic [OFS_W-1:0] ofs;
    logic [OFS_W-1:0] align_mask; // offset bits that must be zero
    logic [XLEN-1:0]  shifted;    // addressed byte moved to lane 0
    logic             ext_b;
    logic             ext_h;
    logic             ext_w;
    logic [XLEN-1:0]  load_val;
    logic [XLEN-1:0]  wdata;
    logic             go;         // word leaves the stage this cycle

    assign ofs     = addr[OFS_W-1:0];
    assign shifted = dmem_rdata >> {ofs, 3'b000};

    // fill bit, zero for lbu/lhu/lwu
    assign ext_b = !is_unsigned && shifted[7];
    assign ext_h = !is_unsigned && shifted[15];
    assign ext_w = !is_unsigned && shifted[31];

    always_comb begin
        case (size)
            2'd0:    load_val = {{(XLEN-8){ext_b}}, shifted[7:0]};
            2'd1:    load_val = {{(XLEN-16){ext_h}}, shifted[15:0]};
            2'd2:    load_val = {{(XLEN-32){ext_w}}, shifted[31:0]};
            default: load_val = shifted;   // ld, offset is 0
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_SEL_LOAD: wdata = load_val;
            WB_SEL_SRC2: wdata = src2;      // csrrw/csrrs
            default:     wdata = alu_result;
        endcase
    end

    assign go       = valid && !blocked;
    assign rf_wen   = go && wen;
    assign rf_waddr = go ? rd : '0;
    assign rf_wdata = go ? wdata : '0;

    assign align_mask = (OFS_W'(1) << size) - OFS_W'(1);

    // misaligned lh/lw/ld would read past the top lane
    always_comb begin
        if (go && wb_sel == WB_SEL_LOAD) begin
            a_load_aligned : assert final ((ofs & align_mask) == '0)
                else $error("misaligned load, size %0d addr %h", size, addr);
        end
    end

endmodule

`default_nettype wire

/* mem_stage/mem_decode.sv */
/*
 * instruction decode for the memory stage
 * load/store kind, access size, signedness and writeback source
 */
`timescale 1ns/1ps
`default_nettype none

module mem_decode import mem_stage_pkg::*; import rv_isa_pkg::*; (
    input  logic                valid,
    input  logic [INST_W-1:0]   inst,
    output logic                is_mem,
    output logic                is_store,
    output logic [1:0]          size,          // log2 of access bytes
    output logic                is_unsigned,
    output logic [REG_W-1:0]    rs2,
    output logic [REG_W-1:0]    rd,
    output logic [WB_SEL_W-1:0] wb_sel,
    output logic                wen
);

    rv_inst_u iw;
    logic     ld_hit;   // legal load encoding
    logic     st_hit;   // legal store encoding
    logic     wr_hit;   // writes rd

    assign iw = inst;

    always_comb begin
        ld_hit      = 1'b0;
        st_hit      = 1'b0;
        wr_hit      = 1'b0;
        size        = 2'd0;
        is_unsigned = 1'b0;
        wb_sel      = WB_SEL_ALU;
        case (iw.i.opcode)
            OPC_LOAD: begin
                ld_hit = 1'b1;
                wb_sel = WB_SEL_LOAD;
                case (iw.i.funct3)
                    F3_B, F3_BU: size = 2'd0;
                    F3_H, F3_HU: size = 2'd1;
                    F3_W, F3_WU: size = 2'd2;
                    F3_D:        size = 2'd3;
                    default:     ld_hit = 1'b0;   // 3'b111 reserved
                endcase
                is_unsigned = iw.i.funct3 inside {F3_BU, F3_HU, F3_WU};
                wr_hit      = ld_hit;
            end
            OPC_STORE: begin
                st_hit = 1'b1;
                case (iw.s.funct3)
                    F3_B:    size = 2'd0;
                    F3_H:    size = 2'd1;
                    F3_W:    size = 2'd2;
                    F3_D:    size = 2'd3;
                    default: st_hit = 1'b0;   // no unsigned stores
                endcase
            end
            OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32,
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: wr_hit = 1'b1;
            OPC_SYSTEM: begin
                if (iw.i.funct3 == F3_CSRRW || iw.i.funct3 == F3_CSRRS) begin
                    wr_hit = 1'b1;
                    wb_sel = WB_SEL_SRC2;   // old csr value read in ex
                end
            end
            default: wr_hit = 1'b0;
        endcase
    end

    assign is_store = valid && st_hit;
    assign is_mem   = valid && (ld_hit || st_hit);
    assign wen      = valid && wr_hit;
    assign rs2      = iw.s.rs2;
    assign rd       = iw.i.rd;

endmodule

`default_nettype wire

/* mem_stage/mem_stage.sv */
/*
 * memory stage of the rv64 integer pipeline
 * ex/mem register, decode, store alignment and load writeback
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_stage_pkg::*; import rv_isa_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // from ex
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [PC_W-1:0]     in_pc,
    input  logic [INST_W-1:0]   in_inst,
    input  logic [XLEN-1:0]     in_alu_result,
    input  logic [XLEN-1:0]     in_src2,
    // to wb
    output logic                out_valid,
    input  logic                out_ready,
    output logic [PC_W-1:0]     out_pc,
    output logic [INST_W-1:0]   out_inst,
    // register file write
    output logic                rf_wen,
    output logic [REG_W-1:0]    rf_waddr,
    output logic [XLEN-1:0]     rf_wdata,
    // wb feedback for rs2 forwarding
    input  logic                wb_wen,
    input  logic [REG_W-1:0]    wb_rd,
    input  logic [XLEN-1:0]     wb_wdata,
    // data memory
    output logic                dmem_req,
    output logic                dmem_we,
    output logic [XLEN-1:0]     dmem_addr,
    output logic [XLEN-1:0]     dmem_wdata,
    output logic [STRB_W-1:0]   dmem_wstrb,
    input  logic [XLEN-1:0]     dmem_rdata,
    input  logic                dmem_ready
);

    // held ex/mem word
    logic                valid;
    logic [INST_W-1:0]   inst;
    logic [XLEN-1:0]     alu_result;
    logic [XLEN-1:0]     src2;
    logic                blocked;   // waiting on dmem_ready

    // decode results
    logic                is_mem;
    logic                is_store;
    logic [1:0]          size;
    logic                is_unsigned;
    logic [REG_W-1:0]    rs2;
    logic [REG_W-1:0]    rd;
    logic [WB_SEL_W-1:0] wb_sel;
    logic                wen;

    assign dmem_addr = alu_result;   // effective address computed in ex

    mem_stage_reg u_reg (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
        .in_alu_result(in_alu_result), .in_src2(in_src2),
        .out_ready(out_ready), .is_mem(is_mem), .dmem_ready(dmem_ready),
        .in_ready(in_ready), .valid(valid), .pc(), .inst(inst),
        .alu_result(alu_result), .src2(src2), .blocked(blocked),
        .dmem_req(dmem_req), .out_valid(out_valid), .out_pc(out_pc), .out_inst(out_inst)
    );

    mem_decode u_decode (
        .valid(valid), .inst(inst),
        .is_mem(is_mem), .is_store(is_store), .size(size), .is_unsigned(is_unsigned),
        .rs2(rs2), .rd(rd), .wb_sel(wb_sel), .wen(wen)
    );

    store_align u_store (
        .is_store(is_store), .size(size), .rs2(rs2), .addr(alu_result), .src2(src2),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_wdata(wb_wdata),
        .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb), .dmem_we(dmem_we)
    );

    load_result u_load (
        .size(size), .is_unsigned(is_unsigned), .addr(alu_result), .dmem_rdata(dmem_rdata),
        .alu_result(alu_result), .src2(src2), .wb_sel(wb_sel),
        .valid(valid), .blocked(blocked), .wen(wen), .rd(rd),
        .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

endmodule

`default_nettype wire

/* mem_stage/mem_stage_reg.sv */
/*
 * ex/mem pipeline register
 * holds one word, stalls on memory and on wb back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_reg import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [PC_W-1:0]   in_pc,
    input  logic [INST_W-1:0] in_inst,
    input  logic [XLEN-1:0]   in_alu_result,
    input  logic [XLEN-1:0]   in_src2,
    input  logic              out_ready,
    input  logic              is_mem,      // held word is a load or store
    input  logic              dmem_ready,
    output logic              in_ready,
    output logic              valid,
    output logic [PC_W-1:0]   pc,
    output logic [INST_W-1:0] inst,
    output logic [XLEN-1:0]   alu_result,
    output logic [XLEN-1:0]   src2,
    output logic              blocked,
    output logic              dmem_req,
    output logic              out_valid,
    output logic [PC_W-1:0]   out_pc,
    output logic [INST_W-1:0] out_inst
);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (in_ready) begin
            valid <= in_valid;   // bubble in when ex has nothing
        end
    end

    // payload, loaded together with valid
    always_ff @(posedge clk) begin
        if (in_ready) begin
            pc         <= in_pc;
            inst       <= in_inst;
            alu_result <= in_alu_result;
            src2       <= in_src2;
        end
    end

    assign dmem_req = valid && is_mem;            // level, held until ready
    assign blocked  = dmem_req && !dmem_ready;

    assign in_ready  = !blocked && out_ready;     // stall ex while memory is busy
    assign out_valid = valid && !blocked;
    assign out_pc    = blocked ? '0 : pc;
    assign out_inst  = blocked ? '0 : inst;

    // request must not drop before memory answers
    a_req_held : assert property (@(posedge clk) disable iff (rst)
        dmem_req && !dmem_ready |=> dmem_req);

endmodule

`default_nettype wire

/* mem_stage/store_align.sv */
/*
 * store data path
 * rs2 forwarding from wb, then byte lane placement and strobes
 */
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_stage_pkg::*; import rv_isa_pkg::*; (
    input  logic              is_store,
    input  logic [1:0]        size,
    input  logic [REG_W-1:0]  rs2,
    input  logic [XLEN-1:0]   addr,
    input  logic [XLEN-1:0]   src2,
    input  logic              wb_wen,
    input  logic [REG_W-1:0]  wb_rd,
    input  logic [XLEN-1:0]   wb_wdata,
    output logic [XLEN-1:0]   dmem_wdata,
    output logic [STRB_W-1:0] dmem_wstrb,
    output logic              dmem_we
);

    logic              fwd_hit;
    logic [XLEN-1:0]   src;
    logic [OFS_W-1:0]  ofs;
    logic [OFS_W-1:0]  align_mask;   // offset bits that must be zero
    logic [STRB_W-1:0] size_strb;    // strobes at offset 0
    logic [XLEN-1:0]   byte_mask;

    // wb result is newer than the src2 read in decode
    assign fwd_hit = wb_wen && (wb_rd == rs2) && (rs2 != '0);
    assign src     = fwd_hit ? wb_wdata : src2;
    assign ofs     = addr[OFS_W-1:0];

    always_comb begin
        case (size)
            2'd0:    size_strb = 8'h01;   // sb
            2'd1:    size_strb = 8'h03;   // sh
            2'd2:    size_strb = 8'h0f;   // sw
            default: size_strb = 8'hff;   // sd
        endcase
    end

    // widen strobes to bits, keeps unused source bytes off the bus
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            byte_mask[8*b +: 8] = {8{size_strb[b]}};
        end
    end

    assign dmem_we    = is_store;
    assign dmem_wdata = is_store ? (src & byte_mask) << {ofs, 3'b000} : '0;
    assign dmem_wstrb = is_store ? size_strb << ofs : '0;

    assign align_mask = (OFS_W'(1) << size) - OFS_W'(1);

    // misaligned sh/sw/sd would lose strobes off the top lane
    always_comb begin
        if (is_store) begin
            a_store_aligned : assert final ((ofs & align_mask) == '0)
                else $error("misaligned store, size %0d addr %h", size, addr);
        end
    end

endmodule

`default_nettype wire
